// ==== compile.f ====
verilog/issuePkg.sv
verilog/dispatchSteer.sv
verilog/issueQueue.sv
verilog/execUnit.sv
verilog/physRegFile.sv
verilog/issueStage.sv
verif/issueStage_chk.sv
verif/issueStageTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module issueStageTb -o issueStageSim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/issueStageSim > sim.log 2>&1
status=$?
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

// ==== verif/issueStageTb.sv ====
`timescale 1ns/1ps

module issueStageTb import issuePkg::*;;

    localparam int QUEUE_SIZE = 8;
    localparam int batchLen = 24;

    logic   clk;
    logic   rst;
    MicroOp uopIn [2];
    logic   flushValid;
    SqN     flushSqN;
    logic   stall [2];
    logic   resultValid [2];
    Tag     resultTag [2];
    SqN     resultSqN [2];
    Word    resultValue [2];

    logic [31:0] lfsr = 32'hc681;
    MicroOp      ops [batchLen];
    Word         expVal [batchLen];
    int          srcA [batchLen];
    int          srcB [batchLen];
    int          resCycle [batchLen];
    bit          seen [batchLen];
    int          idxOfTag [64];
    int          outstanding [2];
    int          cycle;
    int          flushIdx;
    bit          flushed;
    bit          sawStall;
    SqN          seqBase;

    issueStage #(.QUEUE_SIZE(QUEUE_SIZE)) issueStage_inst (
        .clk(clk), .rst(rst), .uopIn(uopIn), .flushValid(flushValid),
        .flushSqN(flushSqN), .stall(stall), .resultValid(resultValid),
        .resultTag(resultTag), .resultSqN(resultSqN), .resultValue(resultValue)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic failRun(input string line);
        $display("%s", line);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic compareResult(input Tag tag, input SqN expSqN, input SqN actSqN,
                                 input Word expWord, input Word actWord);
        if (expSqN !== actSqN || expWord !== actWord)
            failRun($sformatf("Error at %0t: tag %0d sqN %0d value %h, expected sqN %0d value %h",
                              $time, tag, actSqN, actWord, expSqN, expWord));
    endtask

    task automatic compareStall(input int slot, input logic expStall, input logic actStall);
        if (expStall !== actStall)
            failRun($sformatf("Error at %0t: stall[%0d] is %b, expected %b",
                              $time, slot, actStall, expStall));
    endtask

    function automatic Word operand(int src);
        return (src < 0) ? 32'h0 : expVal[src];
    endfunction

    // Mode 0 is random and mode 1 is a multiplier chain
    task automatic buildBatch(input int mode, input int batchNum);
        logic [63:0] prod;
        Word         a;
        Word         b;
        for (int t = 0; t < 64; t++)
            idxOfTag[t] = -1;
        for (int i = 0; i < batchLen; i++) begin
            ops[i] = '0;
            ops[i].valid = 1'b1;
            ops[i].sqN = seqBase + SqN'(i);
            ops[i].fu = (mode == 1) ? fuMul : FuncUnit'(randBits(1));
            if (ops[i].fu == fuAlu)
                ops[i].opcode = OpCode'(randBits(3) % 5);
            else
                ops[i].opcode = OpCode'(5 + randBits(1));
            ops[i].tagDst = Tag'((batchNum * batchLen + i) % 63);
            idxOfTag[ops[i].tagDst] = i;
            if (mode == 1)
                srcA[i] = i - 1;
            else
                srcA[i] = (i == 0 || randBits(1)) ? -1 : int'(randBits(5) % i);
            srcB[i] = (i == 0 || randBits(1)) ? -1 : int'(randBits(5) % i);
            ops[i].tagA = (srcA[i] < 0) ? tagNone : ops[srcA[i]].tagDst;
            ops[i].tagB = (srcB[i] < 0) ? tagNone : ops[srcB[i]].tagDst;
            a = operand(srcA[i]);
            b = operand(srcB[i]);
            prod = {32'b0, a} * {32'b0, b};
            case (ops[i].opcode)
                opAdd: expVal[i] = a + b;
                opSub: expVal[i] = a - b;
                opAnd: expVal[i] = a & b;
                opOr: expVal[i] = a | b;
                opXor: expVal[i] = a ^ b;
                opMul: expVal[i] = prod[31:0];
                default: expVal[i] = prod[63:32];
            endcase
            seen[i] = 1'b0;
            resCycle[i] = 0;
        end
    endtask

    task automatic sampleResults();
        int idx;
        for (int r = 0; r < 2; r++) begin
            if (resultValid[r]) begin
                idx = idxOfTag[resultTag[r]];
                if (idx < 0)
                    failRun($sformatf("Result for tag %0d that is not in the batch",
                                      resultTag[r]));
                if (seen[idx])
                    failRun($sformatf("Tag %0d produced a second result", resultTag[r]));
                if (flushed && idx > flushIdx)
                    failRun($sformatf("Result of op %0d after a flush at op %0d", idx, flushIdx));
                compareResult(resultTag[r], ops[idx].sqN, resultSqN[r],
                              expVal[idx], resultValue[r]);
                if ((srcA[idx] >= 0 && (!seen[srcA[idx]] || resCycle[srcA[idx]] >= cycle)) ||
                    (srcB[idx] >= 0 && (!seen[srcB[idx]] || resCycle[srcB[idx]] >= cycle)))
                    failRun($sformatf("Op %0d finished before one of its sources", idx));
                seen[idx] = 1'b1;
                resCycle[idx] = cycle;
                outstanding[ops[idx].fu]--;
            end
        end
    endtask

    task automatic settle();
        @(negedge clk);
        cycle++;
        sampleResults();
    endtask

    task automatic advance();
        @(posedge clk);
        #1;
    endtask

    // Mode 2 is a random batch with a flush part way through
    task automatic runBatch(input int mode, input int batchNum);
        int next;
        int flushAt;
        int need;
        int waitCycles;
        int room;
        bit done;
        bit ok0;
        buildBatch(mode == 1 ? 1 : 0, batchNum);
        next = 0;
        flushed = 1'b0;
        flushIdx = batchLen - 1;
        flushAt = (mode == 2) ? 6 + int'(randBits(4) % 10) : batchLen + 1;
        outstanding[0] = 0;
        outstanding[1] = 0;
        waitCycles = 0;
        while (next < batchLen && !flushed) begin
            if (next >= flushAt) begin
                flushIdx = int'(randBits(8) % next);
                uopIn[0] = '0;
                uopIn[1] = '0;
                flushValid = 1'b1;
                flushSqN = ops[flushIdx].sqN;
                flushed = 1'b1;
                settle();
                compareStall(0, 1'b1, stall[0]);
                advance();
                flushValid = 1'b0;
            end else begin
                uopIn[0] = ops[next];
                uopIn[1] = (next + 1 < batchLen) ? ops[next + 1] : '0;
                settle();
                for (int s = 0; s < 2; s++) begin
                    if (uopIn[s].valid) begin
                        room = outstanding[uopIn[s].fu];
                        if (s == 1 && uopIn[0].fu == uopIn[1].fu)
                            room++;
                        if (room < QUEUE_SIZE && (s == 0 || !stall[0]))
                            compareStall(s, 1'b0, stall[s]);
                        if (stall[s])
                            sawStall = 1'b1;
                    end
                end
                if (stall[0] && uopIn[1].valid && !stall[1])
                    failRun("Slot 1 was accepted while slot 0 stalled");
                ok0 = !stall[0];
                if (ok0) begin
                    outstanding[uopIn[0].fu]++;
                    next++;
                    if (uopIn[1].valid && !stall[1]) begin
                        outstanding[uopIn[1].fu]++;
                        next++;
                    end
                end
                advance();
                waitCycles++;
                if (waitCycles > 2000)
                    failRun("Timeout waiting for dispatch");
            end
        end
        uopIn[0] = '0;
        uopIn[1] = '0;
        need = flushIdx + 1;
        waitCycles = 0;
        done = 1'b0;
        while (!done) begin
            done = 1'b1;
            for (int i = 0; i < need; i++)
                if (!seen[i])
                    done = 1'b0;
            if (!done) begin
                settle();
                advance();
                waitCycles++;
                if (waitCycles > 500)
                    failRun("Timeout waiting for result drain");
            end
        end
        seqBase = seqBase + SqN'(batchLen);
    endtask

    initial begin
        rst = 1'b1;
        flushValid = 1'b0;
        flushSqN = '0;
        uopIn[0] = '0;
        uopIn[1] = '0;
        cycle = 0;
        seqBase = '0;
        sawStall = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Nothing may broadcast before the first dispatch
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            if (resultValid[0] || resultValid[1])
                failRun("Result bus active after reset without dispatch");
            advance();
        end

        runBatch(0, 0);
        runBatch(0, 1);
        // Only the multiplier chain may count as back-pressure
        sawStall = 1'b0;
        runBatch(1, 2);
        if (!sawStall)
            failRun("Multiplier chain batch never raised a stall");
        runBatch(2, 3);
        runBatch(0, 4);
        runBatch(2, 5);
        runBatch(0, 6);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== verif/issueStage_chk.sv ====
`timescale 1ns/1ps

module issueStage_chk import issuePkg::*; #(
    parameter int QUEUE_SIZE = 8
) (
    input logic                        clk,
    input logic                        rst,
    input logic                        flushValid,
    input SqN                          flushSqN,
    input MicroOp                      issueAlu,
    input MicroOp                      issueMul,
    input logic [$clog2(QUEUE_SIZE):0] freeAlu,
    input logic [$clog2(QUEUE_SIZE):0] freeMul,
    input logic                        resultValid [2],
    input Tag                          resultTag [2],
    input SqN                          resultSqN [2]
);

    // An issued op must have come from a queue that held something
    aluIssueNotEmpty: assert property (@(posedge clk) disable iff (rst)
        issueAlu.valid |-> $past(freeAlu) != QUEUE_SIZE) else $error("ALU queue issued while empty");
    mulIssueNotEmpty: assert property (@(posedge clk) disable iff (rst)
        issueMul.valid |-> $past(freeMul) != QUEUE_SIZE) else $error("MUL queue issued while empty");

    aluTagReal: assert property (@(posedge clk) disable iff (rst)
        resultValid[0] |-> resultTag[0] != tagNone) else $error("ALU bus carried no-register tag");
    mulTagReal: assert property (@(posedge clk) disable iff (rst)
        resultValid[1] |-> resultTag[1] != tagNone) else $error("MUL bus carried no-register tag");

    // Flushed work stays off each bus for as long as it could still be in flight
    aluFlushKill: assert property (@(posedge clk) disable iff (rst)
        flushValid |-> !(resultValid[0] && isOlder(flushSqN, resultSqN[0]))
        ##1 !(resultValid[0] && isOlder($past(flushSqN), resultSqN[0])))
        else $error("ALU result younger than flush");
    mulFlushKill: assert property (@(posedge clk) disable iff (rst)
        flushValid |-> !(resultValid[1] && isOlder(flushSqN, resultSqN[1]))
        ##1 !(resultValid[1] && isOlder($past(flushSqN), resultSqN[1]))
        ##1 !(resultValid[1] && isOlder($past(flushSqN, 2), resultSqN[1]))
        ##1 !(resultValid[1] && isOlder($past(flushSqN, 3), resultSqN[1])))
        else $error("MUL result younger than flush");

endmodule

bind issueStage issueStage_chk #(.QUEUE_SIZE(QUEUE_SIZE)) chk (
    .clk(clk), .rst(rst), .flushValid(flushValid), .flushSqN(flushSqN),
    .issueAlu(issueAlu), .issueMul(issueMul), .freeAlu(freeAlu), .freeMul(freeMul),
    .resultValid(resultValid), .resultTag(resultTag), .resultSqN(resultSqN)
);

// ==== verilog/issueStage.sv ====
`timescale 1ns/1ps

module issueStage import issuePkg::*; #(
    parameter int QUEUE_SIZE  = 8,
    parameter int ALU_LATENCY = 1,
    parameter int MUL_LATENCY = 3
) (
    input  logic   clk,
    input  logic   rst,
    input  MicroOp uopIn [2],
    input  logic   flushValid,
    input  SqN     flushSqN,
    output logic   stall [2],
    output logic   resultValid [2],
    output Tag     resultTag [2],
    output SqN     resultSqN [2],
    output Word    resultValue [2]
);

    localparam int cntBits = $clog2(QUEUE_SIZE) + 1;

    Tag                 readyTagA [2];
    Tag                 readyTagB [2];
    logic               readyA [2];
    logic               readyB [2];
    MicroOp             enqAlu [2];
    MicroOp             enqMul [2];
    logic               clearValid [2];
    Tag                 clearTag [2];
    logic [cntBits-1:0] freeAlu;
    logic [cntBits-1:0] freeMul;
    MicroOp             issueAlu;
    MicroOp             issueMul;
    Tag                 readTag [4];
    Word                readValue [4];

    assign readyTagA[0] = uopIn[0].tagA;
    assign readyTagA[1] = uopIn[1].tagA;
    assign readyTagB[0] = uopIn[0].tagB;
    assign readyTagB[1] = uopIn[1].tagB;

    dispatchSteer #(.QUEUE_SIZE(QUEUE_SIZE)) steer (
        .clk(clk), .rst(rst), .uopIn(uopIn), .flushValid(flushValid),
        .readyA(readyA), .readyB(readyB),
        .resultValid(resultValid), .resultTag(resultTag),
        .freeAlu(freeAlu), .freeMul(freeMul), .stall(stall),
        .enqAlu(enqAlu), .enqMul(enqMul),
        .clearValid(clearValid), .clearTag(clearTag)
    );

    // Units are fully pipelined, so they never push back
    issueQueue #(.QUEUE_SIZE(QUEUE_SIZE), .UNIT(fuAlu)) aluQueue (
        .clk(clk), .rst(rst), .enq(enqAlu),
        .resultValid(resultValid), .resultTag(resultTag),
        .flushValid(flushValid), .flushSqN(flushSqN), .unitStall(1'b0),
        .freeSlots(freeAlu), .issueUop(issueAlu)
    );

    issueQueue #(.QUEUE_SIZE(QUEUE_SIZE), .UNIT(fuMul)) mulQueue (
        .clk(clk), .rst(rst), .enq(enqMul),
        .resultValid(resultValid), .resultTag(resultTag),
        .flushValid(flushValid), .flushSqN(flushSqN), .unitStall(1'b0),
        .freeSlots(freeMul), .issueUop(issueMul)
    );

    execUnit #(.LATENCY(ALU_LATENCY), .UNIT(fuAlu)) aluUnit (
        .clk(clk), .rst(rst), .issueUop(issueAlu),
        .valueA(readValue[0]), .valueB(readValue[1]),
        .flushValid(flushValid), .flushSqN(flushSqN),
        .readTagA(readTag[0]), .readTagB(readTag[1]),
        .resultValid(resultValid[0]), .resultTag(resultTag[0]),
        .resultSqN(resultSqN[0]), .resultValue(resultValue[0])
    );

    execUnit #(.LATENCY(MUL_LATENCY), .UNIT(fuMul)) mulUnit (
        .clk(clk), .rst(rst), .issueUop(issueMul),
        .valueA(readValue[2]), .valueB(readValue[3]),
        .flushValid(flushValid), .flushSqN(flushSqN),
        .readTagA(readTag[2]), .readTagB(readTag[3]),
        .resultValid(resultValid[1]), .resultTag(resultTag[1]),
        .resultSqN(resultSqN[1]), .resultValue(resultValue[1])
    );

    physRegFile regFile (
        .clk(clk), .rst(rst), .readTag(readTag),
        .readyTagA(readyTagA), .readyTagB(readyTagB),
        .clearValid(clearValid), .clearTag(clearTag),
        .writeValid(resultValid), .writeTag(resultTag), .writeValue(resultValue),
        .readValue(readValue), .readyA(readyA), .readyB(readyB)
    );

endmodule

// ==== verilog/physRegFile.sv ====
`timescale 1ns/1ps

module physRegFile import issuePkg::*; (
    input  logic clk,
    input  logic rst,
    input  Tag   readTag [4],
    input  Tag   readyTagA [2],
    input  Tag   readyTagB [2],
    input  logic clearValid [2],
    input  Tag   clearTag [2],
    input  logic writeValid [2],
    input  Tag   writeTag [2],
    input  Word  writeValue [2],
    output Word  readValue [4],
    output logic readyA [2],
    output logic readyB [2]
);

    Word                    values [numPhysRegs];
    logic [numPhysRegs-1:0] ready;
    logic [numPhysRegs-1:0] nextReady;

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (writeValid[w] && writeTag[w] != tagNone)
                values[writeTag[w]] <= writeValue[w];
        end
    end

    // A clear wins since the tag is reallocated after its broadcast
    always_comb begin
        nextReady = ready;
        for (int w = 0; w < 2; w++) begin
            if (writeValid[w])
                nextReady[writeTag[w]] = 1'b1;
        end
        for (int c = 0; c < 2; c++) begin
            if (clearValid[c] && clearTag[c] != tagNone)
                nextReady[clearTag[c]] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready <= '1;
        end else begin
            ready <= nextReady;
        end
    end

    always_comb begin
        for (int p = 0; p < 4; p++)
            readValue[p] = (readTag[p] == tagNone) ? '0 : values[readTag[p]];
        for (int s = 0; s < 2; s++) begin
            readyA[s] = (readyTagA[s] == tagNone) || ready[readyTagA[s]];
            readyB[s] = (readyTagB[s] == tagNone) || ready[readyTagB[s]];
        end
    end

endmodule

// ==== verilog/execUnit.sv ====
`timescale 1ns/1ps

module execUnit import issuePkg::*; #(
    parameter int      LATENCY = 1,
    parameter FuncUnit UNIT    = fuAlu
) (
    input  logic   clk,
    input  logic   rst,
    input  MicroOp issueUop,
    input  Word    valueA,
    input  Word    valueB,
    input  logic   flushValid,
    input  SqN     flushSqN,
    output Tag     readTagA,
    output Tag     readTagB,
    output logic   resultValid,
    output Tag     resultTag,
    output SqN     resultSqN,
    output Word    resultValue
);

    logic [63:0] product;
    Word         computed;
    logic        issueKill;
    logic        stValid [LATENCY];
    logic        stKill [LATENCY];
    Tag          stTag [LATENCY];
    SqN          stSqN [LATENCY];
    Word         stValue [LATENCY];

    // Operands are read from the register file in the issue cycle
    assign readTagA = issueUop.tagA;
    assign readTagB = issueUop.tagB;

    always_comb begin
        product = {32'b0, valueA} * {32'b0, valueB};
        computed = '0;
        if (UNIT == fuMul) begin
            if (issueUop.opcode == opMulHigh)
                computed = product[63:32];
            else
                computed = product[31:0];
        end else begin
            case (issueUop.opcode)
                opAdd: computed = valueA + valueB;
                opSub: computed = valueA - valueB;
                opAnd: computed = valueA & valueB;
                opOr: computed = valueA | valueB;
                opXor: computed = valueA ^ valueB;
                default: computed = '0;
            endcase
        end
    end

    // Anything younger than the branch dies wherever it is
    always_comb begin
        issueKill = flushValid && isOlder(flushSqN, issueUop.sqN);
        for (int i = 0; i < LATENCY; i++)
            stKill[i] = flushValid && isOlder(flushSqN, stSqN[i]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LATENCY; i++)
                stValid[i] <= 1'b0;
        end else begin
            // No broadcast for an op without a destination
            stValid[0] <= issueUop.valid && issueUop.tagDst != tagNone && !issueKill;
            for (int i = 1; i < LATENCY; i++)
                stValid[i] <= stValid[i - 1] && !stKill[i - 1];
        end
    end

    always_ff @(posedge clk) begin
        stTag[0] <= issueUop.tagDst;
        stSqN[0] <= issueUop.sqN;
        stValue[0] <= computed;
        for (int i = 1; i < LATENCY; i++) begin
            stTag[i] <= stTag[i - 1];
            stSqN[i] <= stSqN[i - 1];
            stValue[i] <= stValue[i - 1];
        end
    end

    assign resultValid = stValid[LATENCY-1] && !stKill[LATENCY-1];
    assign resultTag = stTag[LATENCY-1];
    assign resultSqN = stSqN[LATENCY-1];
    assign resultValue = stValue[LATENCY-1];

endmodule

// ==== verilog/issueQueue.sv ====
`timescale 1ns/1ps

module issueQueue import issuePkg::*; #(
    parameter int      QUEUE_SIZE = 8,
    parameter FuncUnit UNIT       = fuAlu
) (
    input  logic                        clk,
    input  logic                        rst,
    input  MicroOp                      enq [2],
    input  logic                        resultValid [2],
    input  Tag                          resultTag [2],
    input  logic                        flushValid,
    input  SqN                          flushSqN,
    input  logic                        unitStall,
    output logic [$clog2(QUEUE_SIZE):0] freeSlots,
    output MicroOp                      issueUop
);

    localparam int idxBits = $clog2(QUEUE_SIZE);
    localparam int cntBits = idxBits + 1;

    // Entries are kept oldest first, valid below count
    MicroOp             entries [QUEUE_SIZE];
    MicroOp             woken [QUEUE_SIZE];
    MicroOp             nextEntries [QUEUE_SIZE];
    logic               eligible [QUEUE_SIZE];
    logic [cntBits-1:0] count;
    logic [cntBits-1:0] nextCount;
    logic               selFound;
    logic [idxBits-1:0] selIdx;
    logic               doIssue;

    assign freeSlots = cntBits'(QUEUE_SIZE) - count;

    // Operand wakeup from both result buses
    always_comb begin
        for (int i = 0; i < QUEUE_SIZE; i++) begin
            woken[i] = entries[i];
            for (int j = 0; j < 2; j++) begin
                if (resultValid[j] && resultTag[j] == entries[i].tagA)
                    woken[i].availA = 1'b1;
                if (resultValid[j] && resultTag[j] == entries[i].tagB)
                    woken[i].availB = 1'b1;
            end
            eligible[i] = (i < count) && woken[i].availA && woken[i].availB;
        end
    end

    // Oldest ready entry wins, i.e. the lowest index
    always_comb begin
        selFound = 1'b0;
        selIdx = '0;
        for (int i = QUEUE_SIZE - 1; i >= 0; i--) begin
            if (eligible[i]) begin
                selFound = 1'b1;
                selIdx = idxBits'(i);
            end
        end
    end

    assign doIssue = selFound && !unitStall && !flushValid;

    always_comb begin
        logic [cntBits-1:0] fill;

        for (int i = 0; i < QUEUE_SIZE; i++)
            nextEntries[i] = woken[i];
        fill = count;

        if (flushValid) begin
            // Keep the prefix that is not younger than the branch
            fill = '0;
            for (int i = 0; i < QUEUE_SIZE; i++) begin
                if (i < count && !isOlder(flushSqN, entries[i].sqN))
                    fill = cntBits'(i + 1);
            end
        end else begin
            if (doIssue) begin
                // Collapse the hole left by the issued entry
                for (int i = 0; i < QUEUE_SIZE - 1; i++) begin
                    if (i >= selIdx)
                        nextEntries[i] = woken[i + 1];
                end
                fill = count - 1'b1;
            end

            // New entries go behind everything already queued
            for (int k = 0; k < 2; k++) begin
                if (enq[k].valid && enq[k].fu == UNIT && fill < QUEUE_SIZE) begin
                    nextEntries[fill[idxBits-1:0]] = enq[k];
                    fill = fill + 1'b1;
                end
            end
        end

        nextCount = fill;
    end

    always_ff @(posedge clk) begin
        entries <= nextEntries;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            issueUop.valid <= 1'b0;
        end else begin
            count <= nextCount;
            if (doIssue) begin
                issueUop <= woken[selIdx];
            end else if (!unitStall) begin
                issueUop.valid <= 1'b0;
            end else if (flushValid && isOlder(flushSqN, issueUop.sqN)) begin
                // Held op on a blocked unit is still killed by a flush
                issueUop.valid <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/dispatchSteer.sv ====
`timescale 1ns/1ps

module dispatchSteer import issuePkg::*; #(
    parameter int QUEUE_SIZE = 8
) (
    input  logic                        clk,
    input  logic                        rst,
    input  MicroOp                      uopIn [2],
    input  logic                        flushValid,
    input  logic                        readyA [2],
    input  logic                        readyB [2],
    input  logic                        resultValid [2],
    input  Tag                          resultTag [2],
    input  logic [$clog2(QUEUE_SIZE):0] freeAlu,
    input  logic [$clog2(QUEUE_SIZE):0] freeMul,
    output logic                        stall [2],
    output MicroOp                      enqAlu [2],
    output MicroOp                      enqMul [2],
    output logic                        clearValid [2],
    output Tag                          clearTag [2]
);

    localparam int cntBits = $clog2(QUEUE_SIZE) + 1;

    // Queues come out of reset one cycle before dispatch opens
    logic running;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    always_comb begin
        logic [cntBits-1:0] roomAlu;
        logic [cntBits-1:0] roomMul;
        logic               blocked;
        logic               accept;
        MicroOp             routed;

        roomAlu = freeAlu;
        roomMul = freeMul;
        blocked = flushValid || !running;

        for (int s = 0; s < 2; s++) begin
            routed = uopIn[s];
            routed.availA = readyA[s];
            routed.availB = readyB[s];

            // Results broadcast this cycle are not in the ready bits yet
            for (int r = 0; r < 2; r++) begin
                if (resultValid[r] && resultTag[r] == uopIn[s].tagA)
                    routed.availA = 1'b1;
                if (resultValid[r] && resultTag[r] == uopIn[s].tagB)
                    routed.availB = 1'b1;
            end

            // Producer in slot 0 of the same bundle
            if (s == 1 && uopIn[0].valid && uopIn[0].tagDst != tagNone) begin
                if (uopIn[0].tagDst == uopIn[s].tagA)
                    routed.availA = 1'b0;
                if (uopIn[0].tagDst == uopIn[s].tagB)
                    routed.availB = 1'b0;
            end

            accept = 1'b0;
            if (uopIn[s].valid && !blocked) begin
                if (uopIn[s].fu == fuAlu && roomAlu != '0) begin
                    accept = 1'b1;
                    roomAlu = roomAlu - 1'b1;
                end else if (uopIn[s].fu == fuMul && roomMul != '0) begin
                    accept = 1'b1;
                    roomMul = roomMul - 1'b1;
                end
            end

            // Everything behind a stalled slot waits too
            if (uopIn[s].valid && !accept)
                blocked = 1'b1;
            stall[s] = blocked;

            enqAlu[s] = routed;
            enqAlu[s].valid = accept && uopIn[s].fu == fuAlu;
            enqMul[s] = routed;
            enqMul[s].valid = accept && uopIn[s].fu == fuMul;

            clearValid[s] = accept && uopIn[s].tagDst != tagNone;
            clearTag[s] = uopIn[s].tagDst;
        end
    end

endmodule

// ==== verilog/issuePkg.sv ====
package issuePkg;

    // Physical register tag, 64 registers
    typedef logic [5:0] Tag;

    // Marks a missing operand or destination, always ready
    localparam Tag tagNone = 6'h3f;

    localparam int numPhysRegs = 64;

    // Program order, compared by wrapping difference
    typedef logic [7:0] SqN;

    typedef logic [31:0] Word;

    typedef enum logic [2:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opMul,
        opMulHigh
    } OpCode;

    typedef enum logic {
        fuAlu,
        fuMul
    } FuncUnit;

    typedef struct packed {
        logic    valid;
        SqN      sqN;
        OpCode   opcode;
        FuncUnit fu;
        Tag      tagA;
        Tag      tagB;
        logic    availA;
        logic    availB;
        Tag      tagDst;
    } MicroOp;

    // True when a is strictly older than b
    function automatic logic isOlder(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return diff[$bits(SqN)-1];
    endfunction

endpackage
